// File: src/mcu8_pkg.sv
`default_nettype none

package mcu8_pkg;

   //////////////////////////////////////////////////
   // widths

   localparam int inst_w    = 18;
   localparam int addr_w    = 12;  // 4k program words
   localparam int data_w    = 8;
   localparam int reg_sel_w = 4;   // s0..sF

   //////////////////////////////////////////////////
   // opcode field, instruction[17:12]
   // odd value of a pair takes kk as operand b
   // bit 13 set in a pair means the carry form

   localparam logic [5:0] op_load_reg = 6'h00;
   localparam logic [5:0] op_load_k   = 6'h01;
   localparam logic [5:0] op_and      = 6'h02;
   localparam logic [5:0] op_or       = 6'h04;
   localparam logic [5:0] op_xor      = 6'h06;
   localparam logic [5:0] op_input    = 6'h08;  // 09 is the pp form
   localparam logic [5:0] op_add      = 6'h10;
   localparam logic [5:0] op_addcy    = 6'h12;
   localparam logic [5:0] op_sub      = 6'h18;
   localparam logic [5:0] op_subcy    = 6'h1A;
   localparam logic [5:0] op_cmp      = 6'h1C;
   localparam logic [5:0] op_cmpcy    = 6'h1E;
   localparam logic [5:0] op_outputk  = 6'h2B;
   localparam logic [5:0] op_output   = 6'h2C;  // 2D is the pp form
   localparam logic [5:0] op_jump     = 6'h22;
   localparam logic [5:0] op_jump_z   = 6'h32;
   localparam logic [5:0] op_jump_nz  = 6'h36;
   localparam logic [5:0] op_jump_c   = 6'h3A;
   localparam logic [5:0] op_jump_nc  = 6'h3E;

   //////////////////////////////////////////////////
   // decoded instruction

   typedef enum logic [2:0] {
      alu_none,
      alu_load,
      alu_and,
      alu_or,
      alu_xor,
      alu_add,
      alu_sub
   } alu_op_t;

   typedef enum logic [2:0] {
      jump_none,
      jump_always,
      jump_z,
      jump_nz,
      jump_c,
      jump_nc
   } jump_kind_t;

   typedef struct packed {
      alu_op_t                alu_op;
      logic                   use_const;   // operand b is kk
      logic                   with_carry;
      logic                   write_reg;   // result goes to sX
      logic                   sets_flags;
      logic                   is_input;
      logic                   is_output;
      logic                   is_outputk;
      jump_kind_t             jump_kind;
      logic [reg_sel_w-1:0]   sx;
      logic [reg_sel_w-1:0]   sy;
      logic [data_w-1:0]      kk;
      logic [addr_w-1:0]      target;      // whole 12-bit field
   } decoded_t;

   typedef struct packed {
      logic [data_w-1:0] result;
      logic              carry;
      logic              zero;
   } alu_result_t;

endpackage

`default_nettype wire

// File: src/mcu8_decoder.sv
`timescale 1ns/1ps
`default_nettype none

module mcu8_decoder
(
   input  wire logic [mcu8_pkg::inst_w-1:0] instruction,
   output mcu8_pkg::decoded_t               dec
);
   import mcu8_pkg::*;

   logic [5:0] opcode;

   assign opcode = instruction[inst_w-1 -: 6];

   always_comb
   begin
      dec           = '0;  // unknown opcode is a no-op
      dec.use_const = instruction[12];
      dec.sx        = instruction[11:8];
      dec.sy        = instruction[7:4];
      dec.kk        = instruction[7:0];
      dec.target    = instruction[11:0];

      // single-value opcodes first
      case (opcode)
         op_outputk: dec.is_outputk = 1'b1;
         op_jump:    dec.jump_kind = jump_always;
         op_jump_z:  dec.jump_kind = jump_z;
         op_jump_nz: dec.jump_kind = jump_nz;
         op_jump_c:  dec.jump_kind = jump_c;
         op_jump_nc: dec.jump_kind = jump_nc;
         default:
         begin
            // register / constant pairs
            case ({opcode[5:1], 1'b0})
               op_load_reg: dec.alu_op = alu_load;
               op_and:      dec.alu_op = alu_and;
               op_or:       dec.alu_op = alu_or;
               op_xor:      dec.alu_op = alu_xor;
               op_add, op_addcy:
                  dec.alu_op = alu_add;
               op_sub, op_subcy, op_cmp, op_cmpcy:
                  dec.alu_op = alu_sub;
               op_input:    dec.is_input = 1'b1;
               op_output:   dec.is_output = 1'b1;
               default:     dec.alu_op = alu_none;
            endcase

            case ({opcode[5:1], 1'b0})
               op_addcy, op_subcy, op_cmpcy:
                  dec.with_carry = 1'b1;
               default:
                  dec.with_carry = 1'b0;
            endcase

            dec.sets_flags = (dec.alu_op != alu_none) && (dec.alu_op != alu_load);
            // compare only touches the flags
            dec.write_reg  = ((dec.alu_op != alu_none) || dec.is_input) &&
                             ({opcode[5:1], 1'b0} != op_cmp) &&
                             ({opcode[5:1], 1'b0} != op_cmpcy);
         end
      endcase
   end

endmodule

`default_nettype wire

// File: src/mcu8_regfile.sv
`timescale 1ns/1ps
`default_nettype none

module mcu8_regfile
(
   input  wire logic                              clk,
   input  wire logic [mcu8_pkg::reg_sel_w-1:0]    sx_sel,
   input  wire logic [mcu8_pkg::reg_sel_w-1:0]    sy_sel,
   input  wire logic                              wr_en,
   input  wire logic [mcu8_pkg::data_w-1:0]       wr_data,
   output logic      [mcu8_pkg::data_w-1:0]       sx_data,
   output logic      [mcu8_pkg::data_w-1:0]       sy_data
);
   import mcu8_pkg::*;

   // one bank of sixteen, zero at start of simulation
   logic [data_w-1:0] regs [2**reg_sel_w] = '{default: '0};

   //////////////////////////////////////////////////
   // two async read ports

   assign sx_data = regs[sx_sel];
   assign sy_data = regs[sy_sel];

   // write back always lands in sX
   always_ff @(posedge clk)
   begin
      if (wr_en)
         regs[sx_sel] <= wr_data;
   end

endmodule

`default_nettype wire

// File: src/mcu8_alu.sv
`timescale 1ns/1ps
`default_nettype none

module mcu8_alu
(
   input  wire logic                          clk,
   input  wire logic                          rst,
   input  wire logic                          exec,
   input  wire mcu8_pkg::decoded_t            dec,
   input  wire logic [mcu8_pkg::data_w-1:0]   sx_data,
   input  wire logic [mcu8_pkg::data_w-1:0]   sy_data,
   input  wire logic [mcu8_pkg::data_w-1:0]   in_port,
   output mcu8_pkg::alu_result_t              res,
   output logic                               z_flag,
   output logic                               c_flag
);
   import mcu8_pkg::*;

   logic [data_w-1:0] operand_b;
   logic              carry_in;
   logic [data_w:0]   sum;   // msb is carry out
   logic [data_w:0]   diff;  // msb is borrow

   //////////////////////////////////////////////////
   // operand select and adders

   assign operand_b = dec.use_const ? dec.kk : sy_data;
   assign carry_in  = dec.with_carry & c_flag;

   assign sum  = {1'b0, sx_data} + {1'b0, operand_b} + {{data_w{1'b0}}, carry_in};
   assign diff = {1'b0, sx_data} - {1'b0, operand_b} - {{data_w{1'b0}}, carry_in};

   always_comb
   begin
      res.carry = 1'b0;  // logic ops clear C
      case (dec.alu_op)
         alu_load: res.result = operand_b;
         alu_and:  res.result = sx_data & operand_b;
         alu_or:   res.result = sx_data | operand_b;
         alu_xor:  res.result = sx_data ^ operand_b;
         alu_add:
         begin
            res.result = sum[data_w-1:0];
            res.carry  = sum[data_w];
         end
         alu_sub:
         begin
            res.result = diff[data_w-1:0];
            res.carry  = diff[data_w];
         end
         default:
            res.result = dec.is_input ? in_port : '0;
      endcase

      // carry forms chain Z across bytes
      res.zero = (res.result == '0) && (!dec.with_carry || z_flag);
   end

   //////////////////////////////////////////////////
   // flags

   always_ff @(posedge clk)
   begin
      if (rst)
      begin
         z_flag <= 1'b0;
         c_flag <= 1'b0;
      end
      else if (exec && dec.sets_flags)
      begin
         z_flag <= res.zero;
         c_flag <= res.carry;
      end
   end

endmodule

`default_nettype wire

// File: src/mcu8_sequencer.sv
`timescale 1ns/1ps
`default_nettype none

module mcu8_sequencer
(
   input  wire logic                          clk,
   input  wire logic                          rst,
   input  wire mcu8_pkg::decoded_t            dec,
   input  wire logic                          z_flag,
   input  wire logic                          c_flag,
   input  wire logic [mcu8_pkg::data_w-1:0]   sx_data,
   input  wire logic [mcu8_pkg::data_w-1:0]   sy_data,
   output logic      [mcu8_pkg::addr_w-1:0]   address,
   output logic                               bram_enable,
   output logic                               exec,
   output logic      [mcu8_pkg::data_w-1:0]   port_id,
   output logic      [mcu8_pkg::data_w-1:0]   out_port,
   output logic                               write_strobe,
   output logic                               k_write_strobe,
   output logic                               read_strobe
);
   import mcu8_pkg::*;

   logic [addr_w-1:0] pc;
   logic              fetch_q;
   logic              exec_q;
   logic              jump_taken;
   logic [data_w-1:0] port_sel;  // sY or kk
   logic [data_w-1:0] port_q;    // held from last output

   //////////////////////////////////////////////////
   // fetch / execute phase

   always_ff @(posedge clk)
   begin
      if (rst)
      begin
         fetch_q <= 1'b0;
         exec_q  <= 1'b0;
      end
      else
      begin
         fetch_q <= ~fetch_q;
         exec_q  <= fetch_q;
      end
   end

   assign bram_enable = fetch_q;
   assign exec        = exec_q;

   //////////////////////////////////////////////////
   // program counter

   always_comb
   begin
      case (dec.jump_kind)
         jump_always: jump_taken = 1'b1;
         jump_z:      jump_taken = z_flag;
         jump_nz:     jump_taken = ~z_flag;
         jump_c:      jump_taken = c_flag;
         jump_nc:     jump_taken = ~c_flag;
         default:     jump_taken = 1'b0;
      endcase
   end

   always_ff @(posedge clk)
   begin
      if (rst)
         pc <= '0;
      else if (exec_q)
         pc <= jump_taken ? dec.target : pc + 1'b1;
   end

   assign address = pc;

   //////////////////////////////////////////////////
   // i/o port

   assign port_sel    = dec.use_const ? dec.kk : sy_data;
   assign read_strobe = exec_q & dec.is_input;   // whole execute phase
   assign port_id     = read_strobe ? port_sel : port_q;

   always_ff @(posedge clk)
   begin
      if (rst)
      begin
         write_strobe   <= 1'b0;
         k_write_strobe <= 1'b0;
      end
      else
      begin
         write_strobe   <= exec_q & dec.is_output;
         k_write_strobe <= exec_q & dec.is_outputk;
      end
   end

   always_ff @(posedge clk)
   begin
      if (exec_q && dec.is_output)
      begin
         out_port <= sx_data;
         port_q   <= port_sel;
      end
      else if (exec_q && dec.is_outputk)
      begin
         out_port <= dec.target[11:4];           // constant
         port_q   <= data_w'(dec.target[3:0]);   // 4-bit port
      end
   end

endmodule

`default_nettype wire

// File: src/mcu8_top.sv
`timescale 1ns/1ps
`default_nettype none

module mcu8_top
(
   input  wire logic                          clk,
   input  wire logic                          rst,
   output logic      [mcu8_pkg::addr_w-1:0]   address,
   input  wire logic [mcu8_pkg::inst_w-1:0]   instruction,
   output logic                               bram_enable,
   input  wire logic [mcu8_pkg::data_w-1:0]   in_port,
   output logic      [mcu8_pkg::data_w-1:0]   out_port,
   output logic      [mcu8_pkg::data_w-1:0]   port_id,
   output logic                               write_strobe,
   output logic                               k_write_strobe,
   output logic                               read_strobe
);
   import mcu8_pkg::*;

   decoded_t          dec;
   alu_result_t       res;
   logic [data_w-1:0] sx_data;
   logic [data_w-1:0] sy_data;
   logic              z_flag;
   logic              c_flag;
   logic              exec;
   logic              wr_en;

   // write back at the end of execute
   assign wr_en = exec & dec.write_reg;

   mcu8_decoder u_decoder (
      .instruction (instruction),
      .dec         (dec)
   );

   mcu8_regfile u_regfile (
      .clk     (clk),
      .sx_sel  (dec.sx),
      .sy_sel  (dec.sy),
      .wr_en   (wr_en),
      .wr_data (res.result),
      .sx_data (sx_data),
      .sy_data (sy_data)
   );

   mcu8_alu u_alu (
      .clk     (clk),
      .rst     (rst),
      .exec    (exec),
      .dec     (dec),
      .sx_data (sx_data),
      .sy_data (sy_data),
      .in_port (in_port),
      .res     (res),
      .z_flag  (z_flag),
      .c_flag  (c_flag)
   );

   mcu8_sequencer u_sequencer (
      .clk            (clk),
      .rst            (rst),
      .dec            (dec),
      .z_flag         (z_flag),
      .c_flag         (c_flag),
      .sx_data        (sx_data),
      .sy_data        (sy_data),
      .address        (address),
      .bram_enable    (bram_enable),
      .exec           (exec),
      .port_id        (port_id),
      .out_port       (out_port),
      .write_strobe   (write_strobe),
      .k_write_strobe (k_write_strobe),
      .read_strobe    (read_strobe)
   );

endmodule

`default_nettype wire

// File: testbench/mcu8_properties.sv
`timescale 1ns/1ps
`default_nettype none

module mcu8_properties
(
   input wire logic clk,
   input wire logic rst,
   input wire logic bram_enable,
   input wire logic write_strobe,
   input wire logic k_write_strobe,
   input wire logic read_strobe
);

   a_one_write_kind : assert property (@(posedge clk) !(write_strobe && k_write_strobe))
      else $error("write_strobe and k_write_strobe high together");

   a_read_in_exec : assert property (@(posedge clk) !(read_strobe && bram_enable))
      else $error("read_strobe high during fetch");

   a_write_pulse : assert property (@(posedge clk) write_strobe |=> !write_strobe)
      else $error("write_strobe longer than one cycle");

   a_k_write_pulse : assert property (@(posedge clk) k_write_strobe |=> !k_write_strobe)
      else $error("k_write_strobe longer than one cycle");

   // first reset edge clears the registered strobes
   a_quiet_in_reset : assert property (@(posedge clk)
      (rst && $past(rst)) |-> !(write_strobe || k_write_strobe || read_strobe))
      else $error("strobe high during reset");

endmodule

bind mcu8_top mcu8_properties u_properties (
   .clk            (clk),
   .rst            (rst),
   .bram_enable    (bram_enable),
   .write_strobe   (write_strobe),
   .k_write_strobe (k_write_strobe),
   .read_strobe    (read_strobe)
);

`default_nettype wire

// File: testbench/tb_mcu8.sv
`timescale 1ns/1ps
`default_nettype none

module tb_mcu8;
   import mcu8_pkg::*;

   localparam logic [1:0] ev_none   = 2'd0;
   localparam logic [1:0] ev_write  = 2'd1;
   localparam logic [1:0] ev_kwrite = 2'd2;
   localparam logic [1:0] ev_read   = 2'd3;

   typedef struct packed {
      logic [inst_w-1:0] inst;
      logic [1:0]        kind;   // strobe expected from this row
      logic [data_w-1:0] pid;
      logic [data_w-1:0] pout;
   } row_t;

   logic              clk = 1'b0;
   logic              rst = 1'b1;
   logic [inst_w-1:0] instruction = '0;
   logic [data_w-1:0] in_port = '0;
   logic [addr_w-1:0] address;
   logic              bram_enable;
   logic [data_w-1:0] out_port;
   logic [data_w-1:0] port_id;
   logic              write_strobe;
   logic              k_write_strobe;
   logic              read_strobe;

   logic [inst_w-1:0] rom [0:2**addr_w-1];
   logic [addr_w-1:0] fetch_addr;
   row_t              table_q[$];
   row_t              exp_q[$];
   logic [data_w-1:0] in_val;
   logic              rst_d = 1'b1;
   int                ev_idx = 0;
   int                errors = 0;
   int                timeouts = 0;

   mcu8_top u_dut (
      .clk            (clk),
      .rst            (rst),
      .address        (address),
      .instruction    (instruction),
      .bram_enable    (bram_enable),
      .in_port        (in_port),
      .out_port       (out_port),
      .port_id        (port_id),
      .write_strobe   (write_strobe),
      .k_write_strobe (k_write_strobe),
      .read_strobe    (read_strobe)
   );

   always #5 clk = ~clk;

   // synchronous program memory
   always @(posedge clk)
   begin
      rst_d <= rst;
      if (bram_enable)
      begin
         fetch_addr = address;
         #1 instruction = rom[fetch_addr];
      end
   end

   //////////////////////////////////////////////////
   // instruction encoders

   function automatic logic [inst_w-1:0] reg_form(logic [5:0] op, logic [3:0] sx, logic [3:0] sy);
      return {op, sx, sy, 4'h0};
   endfunction

   function automatic logic [inst_w-1:0] const_form(logic [5:0] op, logic [3:0] sx,
                                                    logic [7:0] kk);
      return {op | 6'h01, sx, kk};
   endfunction

   function automatic logic [inst_w-1:0] jump_to(logic [5:0] op, logic [11:0] target);
      return {op, target};
   endfunction

   function automatic logic [inst_w-1:0] outk_form(logic [7:0] kk, logic [3:0] port);
      return {op_outputk, kk, port};
   endfunction

   task automatic add_row(input logic [inst_w-1:0] inst, input logic [1:0] kind,
                          input logic [7:0] pid, input logic [7:0] pout);
      row_t r;
      r.inst = inst;
      r.kind = kind;
      r.pid  = pid;
      r.pout = pout;
      table_q.push_back(r);
   endtask

   task automatic check_value(input string what, input logic [7:0] got, input logic [7:0] exp);
      if (got !== exp)
      begin
         errors++;
         $display("** Error at %0t ns: %s is %h, expected %h", $time, what, got, exp);
      end
   endtask

   // strobe monitor, sampled mid-cycle
   always @(negedge clk)
   begin
      if (rst)
      begin
         if (rst_d)
            check_value("outputs in reset",
                        {4'b0, bram_enable, write_strobe, k_write_strobe, read_strobe}, 8'h00);
      end
      else if (write_strobe || k_write_strobe || read_strobe)
      begin
         if (ev_idx >= exp_q.size())
         begin
            errors++;
            $display("unexpected strobe at %0t ns with port_id %h and out_port %h",
                     $time, port_id, out_port);
         end
         else
         begin
            check_value("strobe kind", {6'b0, read_strobe ? ev_read :
                        k_write_strobe ? ev_kwrite : ev_write}, {6'b0, exp_q[ev_idx].kind});
            check_value("port_id", port_id, exp_q[ev_idx].pid);
            if (!read_strobe)
               check_value("out_port", out_port, exp_q[ev_idx].pout);
         end
         ev_idx++;
      end
   end

   task automatic wait_events(input int target);
      int last;
      int cycles;
      last   = ev_idx;
      cycles = 0;
      while (ev_idx < target && timeouts == 0)
      begin
         @(posedge clk);
         if (ev_idx != last)
         begin
            last   = ev_idx;
            cycles = 0;
         end
         else
            cycles++;
         if (cycles > 60)
         begin
            timeouts++;
            $display("timeout: strobe event %0d with port_id %h never came",
                     ev_idx, exp_q[ev_idx].pid);
         end
      end
   endtask

   task automatic build_program();
      add_row(const_form(op_load_k, 4'h0, 8'h5A), ev_none, 0, 0);
      add_row(const_form(op_load_k, 4'h1, 8'h3C), ev_none, 0, 0);
      add_row(reg_form(op_load_reg, 4'h2, 4'h0), ev_none, 0, 0);
      add_row(reg_form(op_and, 4'h2, 4'h1), ev_none, 0, 0);
      add_row(const_form(op_output, 4'h2, 8'h10), ev_write, 8'h10, 8'h5A & 8'h3C);
      add_row(reg_form(op_or, 4'h0, 4'h1), ev_none, 0, 0);
      add_row(const_form(op_output, 4'h0, 8'h11), ev_write, 8'h11, 8'h5A | 8'h3C);
      add_row(const_form(op_xor, 4'h1, 8'hFF), ev_none, 0, 0);
      add_row(const_form(op_output, 4'h1, 8'h12), ev_write, 8'h12, 8'h3C ^ 8'hFF);
      // 0x12F0 + 0x0125, carry out of the low byte
      add_row(const_form(op_load_k, 4'h4, 8'hF0), ev_none, 0, 0);
      add_row(const_form(op_load_k, 4'h5, 8'h12), ev_none, 0, 0);
      add_row(const_form(op_add, 4'h4, 8'h25), ev_none, 0, 0);
      add_row(const_form(op_addcy, 4'h5, 8'h01), ev_none, 0, 0);
      add_row(const_form(op_output, 4'h4, 8'h20), ev_write, 8'h20, 8'h15);
      add_row(const_form(op_output, 4'h5, 8'h21), ev_write, 8'h21, 8'h14);
      // 0x1005 - 0x0010, borrow into the high byte
      add_row(const_form(op_load_k, 4'h6, 8'h05), ev_none, 0, 0);
      add_row(const_form(op_load_k, 4'h7, 8'h10), ev_none, 0, 0);
      add_row(const_form(op_sub, 4'h6, 8'h10), ev_none, 0, 0);
      add_row(const_form(op_subcy, 4'h7, 8'h00), ev_none, 0, 0);
      add_row(const_form(op_output, 4'h6, 8'h22), ev_write, 8'h22, 8'hF5);
      add_row(const_form(op_output, 4'h7, 8'h23), ev_write, 8'h23, 8'h0F);
      // s0 is 0x7E here
      add_row(const_form(op_cmp, 4'h0, 8'h7E), ev_none, 0, 0);         // Z=1 C=0
      add_row(jump_to(op_jump_z, 12'd24), ev_none, 0, 0);
      add_row(const_form(op_output, 4'h0, 8'hEE), ev_none, 0, 0);      // skipped
      add_row(outk_form(8'hA1, 4'h3), ev_kwrite, 8'h03, 8'hA1);
      add_row(jump_to(op_jump_nz, 12'd27), ev_none, 0, 0);             // flags held
      add_row(outk_form(8'hB2, 4'h4), ev_kwrite, 8'h04, 8'hB2);
      add_row(const_form(op_cmp, 4'h0, 8'h80), ev_none, 0, 0);         // borrow
      add_row(jump_to(op_jump_nz, 12'd30), ev_none, 0, 0);
      add_row(const_form(op_output, 4'h0, 8'hEE), ev_none, 0, 0);      // skipped
      add_row(jump_to(op_jump_z, 12'd33), ev_none, 0, 0);
      add_row(jump_to(op_jump_nc, 12'd33), ev_none, 0, 0);
      add_row(outk_form(8'hC3, 4'h5), ev_kwrite, 8'h05, 8'hC3);
      add_row(jump_to(op_jump_c, 12'd35), ev_none, 0, 0);
      add_row(const_form(op_output, 4'h0, 8'hEE), ev_none, 0, 0);      // skipped
      add_row(const_form(op_sub, 4'h0, 8'h7E), ev_none, 0, 0);         // Z=1 C=0
      add_row(jump_to(op_jump_c, 12'd38), ev_none, 0, 0);
      add_row(outk_form(8'hD4, 4'h6), ev_kwrite, 8'h06, 8'hD4);
      add_row(jump_to(op_jump_nc, 12'd40), ev_none, 0, 0);
      add_row(const_form(op_output, 4'h0, 8'hEE), ev_none, 0, 0);      // skipped
      add_row(const_form(op_input, 4'h8, 8'h40), ev_read, 8'h40, 8'h00);
      add_row(const_form(op_add, 4'h8, 8'h07), ev_none, 0, 0);
      add_row(const_form(op_output, 4'h8, 8'h41), ev_write, 8'h41, in_val + 8'h07);
      add_row(jump_to(op_jump, 12'd43), ev_none, 0, 0);                // park here
   endtask

   initial
   begin
      void'($urandom(27994));
      in_val = 8'($urandom);
      build_program();

      // unused words jump to themselves
      for (int a = 0; a < 2**addr_w; a++)
         rom[a] = jump_to(op_jump, 12'(a));
      foreach (table_q[i])
      begin
         rom[i] = table_q[i].inst;
         if (table_q[i].kind != ev_none)
            exp_q.push_back(table_q[i]);
      end

      repeat (4) @(posedge clk);
      #1;
      rst     = 1'b0;
      in_port = in_val;

      // partial run, then reset in the middle
      wait_events(6);
      if (timeouts == 0)
      begin
         @(posedge clk);
         #1 rst = 1'b1;
         repeat (4) @(posedge clk);
         ev_idx = 0;
         #1 rst = 1'b0;
         wait_events(exp_q.size());
      end
      if (timeouts == 0)
         repeat (40) @(posedge clk);   // nothing more may appear

      $display("errors: %0d mismatches, %0d timeouts", errors, timeouts);
      if (errors == 0 && timeouts == 0)
         $display("RESULT: PASS");
      else
         $display("RESULT: FAIL");
      $finish;
   end

endmodule

`default_nettype wire

// File: verilog.f
src/mcu8_pkg.sv
src/mcu8_decoder.sv
src/mcu8_regfile.sv
src/mcu8_alu.sv
src/mcu8_sequencer.sv
src/mcu8_top.sv
testbench/mcu8_properties.sv
testbench/tb_mcu8.sv

// File: run.sh
#!/bin/sh
# build and run the mcu8 testbench with Verilator

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
   -f verilog.f --top-module tb_mcu8 -Mdir obj_dir
if [ $? -ne 0 ]; then
   echo "build failed"
   exit 1
fi

./obj_dir/Vtb_mcu8 > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
   echo "simulation exited with status $status"
   exit 1
fi

if grep -q "^RESULT: PASS$" "$LOG"; then
   exit 0
fi
exit 1
